/* source/nebula_pkg.sv */
// Shared widths, address map and state encodings for the user-area bus fabric
// Regions are 64 KiB, selected by the upper 16 address bits
package nebula_pkg;

    typedef logic [31:0] wb_addr_t; // Byte address
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;  // One enable per byte lane

    localparam int NUM_IO = 38;

    typedef logic [NUM_IO-1:0] gpio_t; // One bit per I/O pin
    typedef logic [3:0]        owner_t; // Team index owning a pin

    localparam owner_t OWNER_NONE = 4'hf;

    // Address map
    localparam wb_addr_t SRAM_BASE   = 32'h3000_0000;
    localparam wb_addr_t GPIO_BASE   = 32'h3001_0000;
    localparam wb_addr_t REGION_MASK = 32'hffff_0000;

    typedef enum logic [1:0] {
        tgt_sram,
        tgt_gpio,
        tgt_none // Unmapped, answered by the decoder itself
    } target_e;

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_e;

endpackage

/* source/wb_if.sv */
// Wishbone classic bus, no clock inside; stb is held until a one-cycle ack
`timescale 1ns/1ps

interface wb_if;

    logic                 cyc;
    logic                 stb;
    logic                 we;
    nebula_pkg::wb_addr_t adr;
    nebula_pkg::wb_data_t dat_w; // Manager to subordinate
    nebula_pkg::wb_sel_t  sel;
    logic                 ack;
    nebula_pkg::wb_data_t dat_r; // Subordinate to manager

    modport manager (
        output cyc, stb, we, adr, dat_w, sel,
        input  ack, dat_r
    );

    modport subordinate (
        input  cyc, stb, we, adr, dat_w, sel,
        output ack, dat_r
    );

endinterface

/* source/wb_arbiter.sv */
// Round-robin arbiter, manager 0 is the host; a grant lasts while cyc stays high
// One idle cycle separates consecutive grants
`timescale 1ns/1ps

module wb_arbiter #(
    parameter int NUM_TEAMS = 4
) (
    input  logic      wb_clk_i,
    input  logic      rst_i,
    wb_if.subordinate mgr [NUM_TEAMS+1],
    wb_if.manager     bus
);

    localparam int NUM_MGR = NUM_TEAMS + 1;
    localparam int IDX_W   = (NUM_MGR > 1) ? $clog2(NUM_MGR) : 1;

    typedef logic [IDX_W-1:0] idx_t;

    nebula_pkg::arb_state_e state_q;
    idx_t                   grant_q;
    idx_t                   last_q;  // Previous owner, search starts after it
    idx_t                   pick;
    logic                   any_req;
    logic                   busy;

    // Manager side flattened into arrays so they can be indexed by grant
    logic                 req_cyc [NUM_MGR];
    logic                 req_stb [NUM_MGR];
    logic                 req_we  [NUM_MGR];
    nebula_pkg::wb_addr_t req_adr [NUM_MGR];
    nebula_pkg::wb_data_t req_dat [NUM_MGR];
    nebula_pkg::wb_sel_t  req_sel [NUM_MGR];

    assign busy = (state_q == nebula_pkg::arb_busy);

    for (genvar g = 0; g < NUM_MGR; g++) begin : g_mgr
        logic is_granted;

        assign is_granted   = busy && (grant_q == idx_t'(g));
        assign req_cyc[g]   = mgr[g].cyc;
        assign req_stb[g]   = mgr[g].stb;
        assign req_we[g]    = mgr[g].we;
        assign req_adr[g]   = mgr[g].adr;
        assign req_dat[g]   = mgr[g].dat_w;
        assign req_sel[g]   = mgr[g].sel;
        assign mgr[g].ack   = is_granted && bus.ack;
        assign mgr[g].dat_r = is_granted ? bus.dat_r : '0; // Others read zero
    end

    // Walk from the farthest candidate down so last+1 has the final say
    always_comb begin
        int unsigned cand;
        pick    = last_q;
        any_req = 1'b0;
        for (int i = NUM_MGR; i >= 1; i--) begin
            cand = (int'(last_q) + i) % NUM_MGR;
            if (req_cyc[cand]) begin
                pick    = idx_t'(cand);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state_q <= nebula_pkg::arb_idle;
            grant_q <= '0;
            last_q  <= idx_t'(NUM_MGR - 1); // First search begins at the host
        end else begin
            case (state_q)
                nebula_pkg::arb_idle: begin
                    if (any_req) begin
                        state_q <= nebula_pkg::arb_busy;
                        grant_q <= pick;
                    end
                end
                nebula_pkg::arb_busy: begin
                    if (!req_cyc[grant_q]) begin // Owner ended its cycle
                        state_q <= nebula_pkg::arb_idle;
                        last_q  <= grant_q;
                    end
                end
                default: state_q <= nebula_pkg::arb_idle;
            endcase
        end
    end

    assign bus.cyc   = busy && req_cyc[grant_q];
    assign bus.stb   = busy && req_stb[grant_q];
    assign bus.we    = busy && req_we[grant_q];
    assign bus.adr   = busy ? req_adr[grant_q] : '0;
    assign bus.dat_w = busy ? req_dat[grant_q] : '0;
    assign bus.sel   = busy ? req_sel[grant_q] : '0;

endmodule

/* source/wb_decoder.sv */
// Region decoder for the shared bus; SRAM and GPIO paths are combinational
// Addresses outside both regions ack one cycle after strobe and read zero
`timescale 1ns/1ps

module wb_decoder (
    input  logic      wb_clk_i,
    input  logic      rst_i,
    wb_if.subordinate bus,
    wb_if.manager     sram,
    wb_if.manager     gpio
);

    nebula_pkg::target_e  tgt;
    nebula_pkg::wb_addr_t region;
    logic                 none_ack_q;

    assign region = bus.adr & nebula_pkg::REGION_MASK;

    always_comb begin
        if (region == nebula_pkg::SRAM_BASE) begin
            tgt = nebula_pkg::tgt_sram;
        end else if (region == nebula_pkg::GPIO_BASE) begin
            tgt = nebula_pkg::tgt_gpio;
        end else begin
            tgt = nebula_pkg::tgt_none;
        end
    end

    // Only the selected target sees cyc and stb
    assign sram.cyc   = bus.cyc && (tgt == nebula_pkg::tgt_sram);
    assign sram.stb   = bus.stb && (tgt == nebula_pkg::tgt_sram);
    assign sram.we    = bus.we;
    assign sram.adr   = bus.adr;
    assign sram.dat_w = bus.dat_w;
    assign sram.sel   = bus.sel;

    assign gpio.cyc   = bus.cyc && (tgt == nebula_pkg::tgt_gpio);
    assign gpio.stb   = bus.stb && (tgt == nebula_pkg::tgt_gpio);
    assign gpio.we    = bus.we;
    assign gpio.adr   = bus.adr;
    assign gpio.dat_w = bus.dat_w;
    assign gpio.sel   = bus.sel;

    // Unmapped responder
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= bus.cyc && bus.stb && (tgt == nebula_pkg::tgt_none) && !none_ack_q;
        end
    end

    always_comb begin
        case (tgt)
            nebula_pkg::tgt_sram: begin
                bus.ack   = sram.ack;
                bus.dat_r = sram.dat_r;
            end
            nebula_pkg::tgt_gpio: begin
                bus.ack   = gpio.ack;
                bus.dat_r = gpio.dat_r;
            end
            default: begin
                bus.ack   = none_ack_q;
                bus.dat_r = '0; // Unmapped reads return zero
            end
        endcase
    end

endmodule

/* source/wb_sram.sv */
// Single-port word SRAM, addresses wrap modulo SRAM_DEPTH words
// Contents are undefined after power-up
`timescale 1ns/1ps

module wb_sram #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic      wb_clk_i,
    input  logic      rst_i,
    wb_if.subordinate bus
);

    localparam int AW = (SRAM_DEPTH > 1) ? $clog2(SRAM_DEPTH) : 1;

    nebula_pkg::wb_data_t mem [SRAM_DEPTH];
    nebula_pkg::wb_data_t rd_q;
    logic [AW-1:0]        word_idx;
    logic                 ack_q;
    logic                 access;

    assign word_idx = AW'((bus.adr >> 2) % 32'(SRAM_DEPTH));
    assign access   = bus.cyc && bus.stb && !ack_q; // Blocks a second ack in a row

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.sel[b]) mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
            rd_q <= mem[word_idx]; // Old word on a write cycle
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rd_q;

endmodule

/* source/gpio_control.sv */
// Pin ownership registers, nibble p%8 of word p/8 names the team driving pin p
// An owner at or above NUM_TEAMS leaves the pin as an undriven input
`timescale 1ns/1ps

module gpio_control #(
    parameter int NUM_TEAMS = 4
) (
    input  logic              wb_clk_i,
    input  logic              rst_i,
    wb_if.subordinate         bus,
    input  nebula_pkg::gpio_t team_gpio_out_i [NUM_TEAMS],
    input  nebula_pkg::gpio_t team_gpio_oeb_i [NUM_TEAMS],
    output nebula_pkg::gpio_t io_out_o,
    output nebula_pkg::gpio_t io_oeb_o
);

    localparam int NUM_WORDS = (nebula_pkg::NUM_IO + 7) / 8;

    nebula_pkg::wb_data_t owner_q [NUM_WORDS];
    nebula_pkg::wb_data_t rd_q;
    logic [2:0]           word_sel;
    logic                 word_ok;
    logic                 ack_q;
    logic                 access;

    assign word_sel = bus.adr[4:2];
    assign word_ok  = (bus.adr[15:5] == '0) && (int'(word_sel) < NUM_WORDS);
    assign access   = bus.cyc && bus.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            for (int w = 0; w < NUM_WORDS; w++) begin
                owner_q[w] <= {8{nebula_pkg::OWNER_NONE}}; // No pin owned
            end
        end else begin
            ack_q <= access;
            if (access && bus.we && word_ok) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.sel[b]) owner_q[word_sel][8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
        end
    end

    // Offsets past the owner words read as zero
    always_ff @(posedge wb_clk_i) begin
        if (access) rd_q <= word_ok ? owner_q[word_sel] : '0;
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rd_q;

    // Per-pin output mux
    always_comb begin
        nebula_pkg::owner_t own;
        io_out_o = '0;
        io_oeb_o = '1;
        for (int p = 0; p < nebula_pkg::NUM_IO; p++) begin
            own = owner_q[p / 8][(p % 8) * 4 +: 4];
            for (int t = 0; t < NUM_TEAMS; t++) begin
                if (own == nebula_pkg::owner_t'(t)) begin
                    io_out_o[p] = team_gpio_out_i[t][p];
                    io_oeb_o[p] = team_gpio_oeb_i[t][p]; // Active low enable
                end
            end
        end
    end

endmodule

/* source/nebula_top.sv */
// Shared Wishbone fabric for the host and NUM_TEAMS team managers (NUM_TEAMS <= 15)
// Idle-bus latency from stb to ack is 2 cycles
`timescale 1ns/1ps

module nebula_top #(
    parameter int NUM_TEAMS  = 4,
    parameter int SRAM_DEPTH = 256
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_i,

    // Host manager port
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_we_i,
    input  nebula_pkg::wb_sel_t  wbs_sel_i,
    input  nebula_pkg::wb_addr_t wbs_adr_i,
    input  nebula_pkg::wb_data_t wbs_dat_i,
    output logic                 wbs_ack_o,
    output nebula_pkg::wb_data_t wbs_dat_o,

    // Team manager ports
    input  logic                 team_cyc_i [NUM_TEAMS],
    input  logic                 team_stb_i [NUM_TEAMS],
    input  logic                 team_we_i  [NUM_TEAMS],
    input  nebula_pkg::wb_sel_t  team_sel_i [NUM_TEAMS],
    input  nebula_pkg::wb_addr_t team_adr_i [NUM_TEAMS],
    input  nebula_pkg::wb_data_t team_dat_i [NUM_TEAMS],
    output logic                 team_ack_o [NUM_TEAMS],
    output nebula_pkg::wb_data_t team_dat_o [NUM_TEAMS],

    // Team pins and the pad outputs
    input  nebula_pkg::gpio_t    team_gpio_out_i [NUM_TEAMS],
    input  nebula_pkg::gpio_t    team_gpio_oeb_i [NUM_TEAMS],
    output nebula_pkg::gpio_t    io_out_o,
    output nebula_pkg::gpio_t    io_oeb_o
);

    wb_if mgr_bus [NUM_TEAMS+1] (); // Index 0 is the host
    wb_if shared_bus ();
    wb_if sram_bus ();
    wb_if gpio_bus ();

    assign mgr_bus[0].cyc   = wbs_cyc_i;
    assign mgr_bus[0].stb   = wbs_stb_i;
    assign mgr_bus[0].we    = wbs_we_i;
    assign mgr_bus[0].sel   = wbs_sel_i;
    assign mgr_bus[0].adr   = wbs_adr_i;
    assign mgr_bus[0].dat_w = wbs_dat_i;
    assign wbs_ack_o        = mgr_bus[0].ack;
    assign wbs_dat_o        = mgr_bus[0].dat_r;

    for (genvar k = 0; k < NUM_TEAMS; k++) begin : g_team
        assign mgr_bus[k+1].cyc   = team_cyc_i[k];
        assign mgr_bus[k+1].stb   = team_stb_i[k];
        assign mgr_bus[k+1].we    = team_we_i[k];
        assign mgr_bus[k+1].sel   = team_sel_i[k];
        assign mgr_bus[k+1].adr   = team_adr_i[k];
        assign mgr_bus[k+1].dat_w = team_dat_i[k];
        assign team_ack_o[k]      = mgr_bus[k+1].ack;
        assign team_dat_o[k]      = mgr_bus[k+1].dat_r;
    end

    wb_arbiter #(.NUM_TEAMS(NUM_TEAMS)) wb_arbiter_i (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .mgr      (mgr_bus),
        .bus      (shared_bus)
    );

    wb_decoder wb_decoder_i (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .bus      (shared_bus),
        .sram     (sram_bus),
        .gpio     (gpio_bus)
    );

    wb_sram #(.SRAM_DEPTH(SRAM_DEPTH)) wb_sram_i (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .bus      (sram_bus)
    );

    gpio_control #(.NUM_TEAMS(NUM_TEAMS)) gpio_control_i (
        .wb_clk_i        (wb_clk_i),
        .rst_i           (rst_i),
        .bus             (gpio_bus),
        .team_gpio_out_i (team_gpio_out_i),
        .team_gpio_oeb_i (team_gpio_oeb_i),
        .io_out_o        (io_out_o),
        .io_oeb_o        (io_oeb_o)
    );

endmodule

/* dv/tb_clock.sv */
// Testbench clock with a 100 ns period, reset high for the first 5 rising edges
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

/* dv/nebula_tb.sv */
// Testbench for nebula_top at default parameters (4 teams, 256 SRAM words)
// Stimulus assumes five managers for the contention burst
`timescale 1ns/1ps

module nebula_tb;

    localparam int NUM_TEAMS  = 4;
    localparam int SRAM_DEPTH = 256;
    localparam int NUM_MGR    = NUM_TEAMS + 1;
    localparam int MAX_CYCLES = 20000;

    logic clk;
    logic rst;
    int   cycle = 0;

    // Index 0 is the host, index k is team k-1
    logic                 m_cyc [NUM_MGR];
    logic                 m_stb [NUM_MGR];
    logic                 m_we  [NUM_MGR];
    nebula_pkg::wb_sel_t  m_sel [NUM_MGR];
    nebula_pkg::wb_addr_t m_adr [NUM_MGR];
    nebula_pkg::wb_data_t m_dat [NUM_MGR];
    logic                 m_ack [NUM_MGR];
    nebula_pkg::wb_data_t m_rd  [NUM_MGR];
    int                   waited [NUM_MGR]; // Other acks seen while this manager waits

    logic                 team_cyc [NUM_TEAMS];
    logic                 team_stb [NUM_TEAMS];
    logic                 team_we  [NUM_TEAMS];
    nebula_pkg::wb_sel_t  team_sel [NUM_TEAMS];
    nebula_pkg::wb_addr_t team_adr [NUM_TEAMS];
    nebula_pkg::wb_data_t team_dat [NUM_TEAMS];
    logic                 team_ack [NUM_TEAMS];
    nebula_pkg::wb_data_t team_rd  [NUM_TEAMS];
    nebula_pkg::gpio_t    pin_out  [NUM_TEAMS];
    nebula_pkg::gpio_t    pin_oeb  [NUM_TEAMS];
    nebula_pkg::gpio_t    io_out;
    nebula_pkg::gpio_t    io_oeb;
    nebula_pkg::gpio_t    exp_out;
    nebula_pkg::gpio_t    exp_oeb;

    nebula_pkg::wb_data_t sram_mdl  [SRAM_DEPTH];
    logic                 sram_vld  [SRAM_DEPTH];
    nebula_pkg::wb_data_t owner_mdl [5];
    int                   picked    [16]; // SRAM words used across the tests
    logic                 pin_chk;        // Off while the owner model lags the DUT
    logic [31:0]          rng;

    tb_clock tb_clock_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    nebula_top #(.NUM_TEAMS(NUM_TEAMS), .SRAM_DEPTH(SRAM_DEPTH)) nebula_top_i (
        .wb_clk_i        (clk),
        .rst_i           (rst),
        .wbs_cyc_i       (m_cyc[0]),
        .wbs_stb_i       (m_stb[0]),
        .wbs_we_i        (m_we[0]),
        .wbs_sel_i       (m_sel[0]),
        .wbs_adr_i       (m_adr[0]),
        .wbs_dat_i       (m_dat[0]),
        .wbs_ack_o       (m_ack[0]),
        .wbs_dat_o       (m_rd[0]),
        .team_cyc_i      (team_cyc),
        .team_stb_i      (team_stb),
        .team_we_i       (team_we),
        .team_sel_i      (team_sel),
        .team_adr_i      (team_adr),
        .team_dat_i      (team_dat),
        .team_ack_o      (team_ack),
        .team_dat_o      (team_rd),
        .team_gpio_out_i (pin_out),
        .team_gpio_oeb_i (pin_oeb),
        .io_out_o        (io_out),
        .io_oeb_o        (io_oeb)
    );

    for (genvar k = 0; k < NUM_TEAMS; k++) begin : g_team
        assign team_cyc[k] = m_cyc[k+1];
        assign team_stb[k] = m_stb[k+1];
        assign team_we[k]  = m_we[k+1];
        assign team_sel[k] = m_sel[k+1];
        assign team_adr[k] = m_adr[k+1];
        assign team_dat[k] = m_dat[k+1];
        assign m_ack[k+1]  = team_ack[k];
        assign m_rd[k+1]   = team_rd[k];
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input nebula_pkg::wb_data_t exp,
                               input nebula_pkg::wb_data_t act);
        assert (act === exp)
            else fail_run($sformatf("Error %s: expected %h, actual %h", test, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic draw(output logic [31:0] v);
        rng = xorshift32(rng);
        v   = rng;
    endtask

    function automatic nebula_pkg::wb_data_t merge_bytes(input nebula_pkg::wb_data_t old_w,
            input nebula_pkg::wb_data_t new_w, input nebula_pkg::wb_sel_t sel);
        nebula_pkg::wb_data_t mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{sel[b]}};
        end
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic nebula_pkg::wb_addr_t sram_addr(input int idx);
        return nebula_pkg::SRAM_BASE + nebula_pkg::wb_addr_t'(idx * 4);
    endfunction

    function automatic nebula_pkg::wb_addr_t owner_addr(input int word);
        return nebula_pkg::GPIO_BASE + nebula_pkg::wb_addr_t'(word * 4);
    endfunction

    // One classic cycle, stb held until ack; lat counts edges from first stb sample to ack
    task automatic bus_xfer(input int m, input logic we, input nebula_pkg::wb_addr_t adr,
                            input nebula_pkg::wb_data_t dat, input nebula_pkg::wb_sel_t sel,
                            output nebula_pkg::wb_data_t rd, output int lat);
        int edges;
        edges = 0;
        @(posedge clk);
        m_cyc[m] <= 1'b1;
        m_stb[m] <= 1'b1;
        m_we[m]  <= we;
        m_adr[m] <= adr;
        m_dat[m] <= dat;
        m_sel[m] <= sel;
        do begin
            @(posedge clk);
            edges++;
        end while (!m_ack[m]);
        rd  = m_rd[m];
        lat = edges - 1;
        m_cyc[m] <= 1'b0;
        m_stb[m] <= 1'b0;
        m_we[m]  <= 1'b0;
    endtask

    task automatic sram_write(input int m, input int idx, input nebula_pkg::wb_data_t d,
                              input nebula_pkg::wb_sel_t sel, output int lat);
        nebula_pkg::wb_data_t rd;
        bus_xfer(m, 1'b1, sram_addr(idx), d, sel, rd, lat);
        sram_mdl[idx] = merge_bytes(sram_mdl[idx], d, sel);
        sram_vld[idx] = 1'b1;
    endtask

    task automatic sram_check(input int m, input int idx, input string test, output int lat);
        nebula_pkg::wb_data_t rd;
        bus_xfer(m, 1'b0, sram_addr(idx), '0, 4'hf, rd, lat);
        check_value(test, sram_mdl[idx], rd);
    endtask

    task automatic owner_write(input int word, input nebula_pkg::wb_data_t d,
                               input nebula_pkg::wb_sel_t sel);
        nebula_pkg::wb_data_t rd;
        int                   lat;
        bus_xfer(0, 1'b1, owner_addr(word), d, sel, rd, lat);
        owner_mdl[word] = merge_bytes(owner_mdl[word], d, sel);
    endtask

    task automatic read_burst(input int m);
        int lat;
        for (int i = 0; i < 6; i++) begin
            sram_check(m, picked[(m * 3 + i) % 16], "read under contention", lat);
        end
    endtask

    // Expected pads, pin p follows nibble p%8 of owner word p/8
    always_comb begin
        nebula_pkg::owner_t own;
        exp_out = '0;
        exp_oeb = '1;
        for (int p = 0; p < nebula_pkg::NUM_IO; p++) begin
            own = nebula_pkg::owner_t'(owner_mdl[p / 8] >> (4 * (p % 8)));
            if (int'(own) < NUM_TEAMS) begin
                exp_out[p] = pin_out[own][p];
                exp_oeb[p] = pin_oeb[own][p];
            end
        end
    end

    // Round robin lets at most NUM_TEAMS other grants pass a waiting manager
    always @(posedge clk) begin
        logic other;
        for (int g = 0; g < NUM_MGR; g++) begin
            other = 1'b0;
            for (int h = 0; h < NUM_MGR; h++) begin
                if (h != g && m_ack[h]) other = 1'b1;
            end
            if (rst || !m_cyc[g] || m_ack[g]) waited[g] <= 0;
            else if (other) waited[g] <= waited[g] + 1;
        end
    end

    for (genvar g = 0; g < NUM_MGR; g++) begin : g_chk
        assert property (@(posedge clk) disable iff (rst) m_ack[g] |-> m_cyc[g])
            else fail_run($sformatf("Manager %0d saw ack while its cyc was low", g));
        assert property (@(posedge clk) disable iff (rst) waited[g] <= NUM_TEAMS)
            else fail_run($sformatf("Manager %0d waited through too many grants", g));
    end

    assert property (@(posedge clk) disable iff (rst || !pin_chk)
                     io_out === exp_out && io_oeb === exp_oeb)
        else fail_run($sformatf("Error pin ownership: expected out %h oeb %h, actual out %h oeb %h",
                                exp_out, exp_oeb, io_out, io_oeb));

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) fail_run($sformatf("Timeout after %0d cycles", MAX_CYCLES));
    end

    initial begin
        nebula_pkg::wb_data_t d;
        nebula_pkg::wb_data_t rd;
        logic [31:0]          r;
        int                   lat;
        int                   l1;
        int                   l2;

        for (int g = 0; g < NUM_MGR; g++) begin
            m_cyc[g] = 1'b0;
            m_stb[g] = 1'b0;
            m_we[g]  = 1'b0;
            m_sel[g] = '0;
            m_adr[g] = '0;
            m_dat[g] = '0;
        end
        for (int t = 0; t < NUM_TEAMS; t++) begin
            pin_out[t] = '1; // Opposite of the unowned pad values
            pin_oeb[t] = '0;
        end
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            sram_vld[i] = 1'b0;
        end
        for (int w = 0; w < 5; w++) begin
            owner_mdl[w] = '1;
        end
        pin_chk = 1'b1;
        rng     = 32'h1d01;

        do begin
            @(posedge clk);
        end while (rst);

        assert (io_oeb === '1 && io_out === '0)
            else fail_run("Pad outputs are not at their reset values");
        for (int g = 0; g < NUM_MGR; g++) begin
            assert (!m_ack[g]) else fail_run($sformatf("Manager %0d ack high after reset", g));
        end

        // SRAM, a word is written in full before any partial write
        for (int i = 0; i < 16; i++) begin
            draw(r);
            picked[i] = (i < 12) ? int'(r % 32'(SRAM_DEPTH)) : picked[i - 12]; // Revisits
            draw(d);
            draw(r);
            sram_write(0, picked[i], d, sram_vld[picked[i]] ? r[3:0] : 4'hf, lat);
            check_value("sram write latency", 2, lat);
        end
        for (int i = 0; i < 16; i++) begin
            sram_check(0, picked[i], "sram read-back", lat);
            check_value("sram read latency", 2, lat);
        end

        @(posedge clk);
        pin_chk <= 1'b0;
        for (int w = 0; w < 5; w++) begin
            for (int n = 0; n < 8; n++) begin
                draw(r);
                d[4*n +: 4] = (r % 6 < 4) ? 4'(r % 6) : nebula_pkg::OWNER_NONE;
            end
            owner_write(w, d, 4'hf);
        end
        draw(d);
        owner_write(1, d, 4'b0101); // Random nibbles, some owners past NUM_TEAMS
        @(posedge clk);
        pin_chk <= 1'b1;
        for (int w = 0; w < 5; w++) begin
            bus_xfer(0, 1'b0, owner_addr(w), '0, 4'hf, rd, lat);
            check_value("owner read-back", owner_mdl[w], rd);
        end
        repeat (24) begin
            @(posedge clk);
            for (int t = 0; t < NUM_TEAMS; t++) begin
                draw(r);
                draw(d);
                pin_out[t] <= {d[5:0], r};
                draw(r);
                draw(d);
                pin_oeb[t] <= {d[5:0], r};
            end
        end

        // Unmapped region and the spare GPIO offsets
        bus_xfer(0, 1'b0, 32'h4000_0010, '0, 4'hf, rd, lat);
        check_value("unmapped read", 0, rd);
        draw(d);
        bus_xfer(0, 1'b1, 32'h3100_0000 | sram_addr(picked[0]), d, 4'hf, rd, lat);
        bus_xfer(0, 1'b1, 32'h3011_0000, d, 4'hf, rd, lat);
        bus_xfer(0, 1'b1, owner_addr(6), d, 4'hf, rd, lat);
        bus_xfer(0, 1'b0, owner_addr(6), '0, 4'hf, rd, lat);
        check_value("gpio spare offset read", 0, rd);
        sram_check(0, picked[0], "sram after unmapped write", lat);
        bus_xfer(0, 1'b0, owner_addr(0), '0, 4'hf, rd, lat);
        check_value("owner after unmapped write", owner_mdl[0], rd);

        // Host and two teams start on the same edge
        draw(d);
        draw(r);
        fork
            sram_write(0, 10, d, 4'hf, lat);
            sram_write(1, 20, r, 4'hf, l1);
            sram_write(2, 30, d ^ r, 4'hf, l2);
        join
        sram_check(0, 20, "team 0 write seen by host", lat);
        sram_check(0, 30, "team 1 write seen by host", lat);
        sram_check(0, 10, "host write under contention", lat);
        fork
            read_burst(0);
            read_burst(1);
            read_burst(2);
            read_burst(3);
            read_burst(4);
        join

        repeat (2) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* build.f */
source/nebula_pkg.sv
source/wb_if.sv
source/wb_arbiter.sv
source/wb_decoder.sv
source/wb_sram.sv
source/gpio_control.sv
source/nebula_top.sv
dv/tb_clock.sv
dv/nebula_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the fabric testbench with Verilator, exit status is nonzero on failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module nebula_tb -f build.f -o nebula_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/nebula_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
